/* Bender.yml */
package:
  name: csr_data_unit

sources:
  # Design sources in compile order
  - hdl/csr_pkg.sv
  - hdl/fpu_csr_if.sv
  - hdl/fcsr_bank.sv
  - hdl/csr_machine_regs.sv
  - hdl/csr_data_unit.sv

  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_csr_data_unit.sv

/* hdl/csr_data_unit.sv */
/*
 * CSR data block top level
 * Plain ports mapped onto the FPU links, control bank and CSR decode
 */
`timescale 1ns/1ps

module csr_data_unit
    import csr_pkg::*;
#(
    parameter int CORE_ID = 0
) (
    input  logic                          clk,
    input  logic                          reset,

    input  xlen_t                         startup_arg,
    input  ctr_t                          cycles,
    input  ctr_t                          instret,
    input  wmask_t                        active_warps,
    input  tmask_t  [NUM_WARPS-1:0]       thread_masks,

    // CSR read port
    input  logic                          read_enable,
    input  wid_t                          read_wid,
    input  csr_addr_t                     read_addr,
    output xlen_t                         read_data_ro,
    output xlen_t                         read_data_rw,
    output logic                          read_addr_invalid,

    // CSR write port
    input  logic                          write_enable,
    input  wid_t                          write_wid,
    input  csr_addr_t                     write_addr,
    input  xlen_t                         write_data,
    output logic                          write_addr_invalid,

    // FPU blocks, one entry per block
    input  logic    [NUM_FPU_BLOCKS-1:0]  fpu_flag_valid,
    input  wid_t    [NUM_FPU_BLOCKS-1:0]  fpu_flag_wid,
    input  fflags_t [NUM_FPU_BLOCKS-1:0]  fpu_flags,
    input  wid_t    [NUM_FPU_BLOCKS-1:0]  fpu_frm_wid,
    output frm_t    [NUM_FPU_BLOCKS-1:0]  fpu_frm
);

    fcsr_wr_e fcsr_wr_kind;
    wid_t     fcsr_wr_wid;
    fcsr_t    fcsr_wr_data;
    fcsr_t    fcsr_rd_value;

    fpu_csr_if fpu_if [NUM_FPU_BLOCKS] ();

    // FPU side of each link driven from the flat ports
    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_fpu_bind
        assign fpu_if[i].write_enable = fpu_flag_valid[i];
        assign fpu_if[i].write_wid    = fpu_flag_wid[i];
        assign fpu_if[i].write_fflags = fpu_flags[i];
        assign fpu_if[i].read_wid     = fpu_frm_wid[i];
        assign fpu_frm[i]             = fpu_if[i].read_frm;
    end

    fcsr_bank fcsr_bank (
        .clk           (clk),
        .reset         (reset),
        .fcsr_wr_kind  (fcsr_wr_kind),
        .fcsr_wr_wid   (fcsr_wr_wid),
        .fcsr_wr_data  (fcsr_wr_data),
        .read_wid      (read_wid),
        .fcsr_rd_value (fcsr_rd_value),
        .fpu           (fpu_if)
    );

    csr_machine_regs #(
        .CORE_ID (CORE_ID)
    ) csr_machine_regs (
        .clk                (clk),
        .reset              (reset),
        .startup_arg        (startup_arg),
        .cycles             (cycles),
        .instret            (instret),
        .active_warps       (active_warps),
        .thread_masks       (thread_masks),
        .read_enable        (read_enable),
        .read_wid           (read_wid),
        .read_addr          (read_addr),
        .write_enable       (write_enable),
        .write_wid          (write_wid),
        .write_addr         (write_addr),
        .write_data         (write_data),
        .fcsr_rd_value      (fcsr_rd_value),
        .fcsr_wr_kind       (fcsr_wr_kind),
        .fcsr_wr_wid        (fcsr_wr_wid),
        .fcsr_wr_data       (fcsr_wr_data),
        .read_data_ro       (read_data_ro),
        .read_data_rw       (read_data_rw),
        .read_addr_invalid  (read_addr_invalid),
        .write_addr_invalid (write_addr_invalid)
    );

endmodule

/* hdl/csr_machine_regs.sv */
/*
 * CSR address decode, machine scratch register and read multiplexing
 */
`timescale 1ns/1ps

module csr_machine_regs
    import csr_pkg::*;
#(
    parameter int CORE_ID = 0
) (
    input  logic                    clk,
    input  logic                    reset,

    input  xlen_t                   startup_arg,
    input  ctr_t                    cycles,
    input  ctr_t                    instret,
    input  wmask_t                  active_warps,
    input  tmask_t [NUM_WARPS-1:0]  thread_masks,

    input  logic                    read_enable,
    input  wid_t                    read_wid,
    input  csr_addr_t               read_addr,

    input  logic                    write_enable,
    input  wid_t                    write_wid,
    input  csr_addr_t               write_addr,
    input  xlen_t                   write_data,

    // Control register bank
    input  fcsr_t                   fcsr_rd_value,
    output fcsr_wr_e                fcsr_wr_kind,
    output wid_t                    fcsr_wr_wid,
    output fcsr_t                   fcsr_wr_data,

    output xlen_t                   read_data_ro,
    output xlen_t                   read_data_rw,
    output logic                    read_addr_invalid,
    output logic                    write_addr_invalid
);

    xlen_t mscratch;
    logic  write_known;
    logic  read_known;

    // Scratch register, seeded from the startup argument
    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= startup_arg;
        end else if (write_enable && (write_addr == CSR_MSCRATCH)) begin
            mscratch <= write_data;
        end
    end

    // Write decode
    always_comb begin
        fcsr_wr_kind = NONE;
        fcsr_wr_data = '0;
        write_known  = 1'b1;
        case (write_addr)
            CSR_FFLAGS: begin
                fcsr_wr_kind = FFLAGS;
                fcsr_wr_data = {{FRM_BITS{1'b0}}, write_data[FFLAGS_BITS-1:0]};
            end
            CSR_FRM: begin
                fcsr_wr_kind = FRM;
                fcsr_wr_data = {write_data[FRM_BITS-1:0], {FFLAGS_BITS{1'b0}}};
            end
            CSR_FCSR: begin
                fcsr_wr_kind = FCSR;
                fcsr_wr_data = write_data[FCSR_BITS-1:0];
            end
            CSR_MSCRATCH: begin
            end
            // Trap and supervisor registers swallow writes
            CSR_SATP, CSR_MSTATUS, CSR_MNSTATUS, CSR_MEDELEG, CSR_MIDELEG,
            CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0: begin
            end
            default: begin
                write_known = 1'b0;
            end
        endcase
        if (!write_enable) begin
            fcsr_wr_kind = NONE;
        end
    end

    assign fcsr_wr_wid        = write_wid;
    assign write_addr_invalid = write_enable && !write_known;

    // Read decode
    always_comb begin
        read_data_ro = '0;
        read_data_rw = '0;
        read_known   = 1'b1;
        case (read_addr)
            CSR_MVENDORID:      read_data_ro = VENDOR_ID;
            CSR_MARCHID:        read_data_ro = ARCH_ID;
            CSR_MIMPID:         read_data_ro = IMPL_ID;
            CSR_MISA:           read_data_ro = MISA_VALUE;

            CSR_FFLAGS:   read_data_rw = xlen_t'(fcsr_rd_value[FFLAGS_BITS-1:0]);
            CSR_FRM:      read_data_rw = xlen_t'(fcsr_rd_value[FCSR_BITS-1:FFLAGS_BITS]);
            CSR_FCSR:     read_data_rw = xlen_t'(fcsr_rd_value);
            CSR_MSCRATCH: read_data_rw = mscratch;

            CSR_WARP_ID:        read_data_ro = xlen_t'(read_wid);
            CSR_CORE_ID:        read_data_ro = xlen_t'(CORE_ID);
            CSR_ACTIVE_THREADS: read_data_ro = xlen_t'(thread_masks[read_wid]);
            CSR_ACTIVE_WARPS:   read_data_ro = xlen_t'(active_warps);
            CSR_NUM_THREADS:    read_data_ro = xlen_t'(NUM_THREADS);
            CSR_NUM_WARPS:      read_data_ro = xlen_t'(NUM_WARPS);
            CSR_NUM_CORES:      read_data_ro = xlen_t'(NUM_CORES);
            CSR_LOCAL_MEM_BASE: read_data_ro = LMEM_BASE;

            // 64-bit counters split into halves
            CSR_MCYCLE:         read_data_ro = cycles[31:0];
            CSR_MCYCLEH:        read_data_ro = cycles[63:32];
            CSR_MINSTRET:       read_data_ro = instret[31:0];
            CSR_MINSTRETH:      read_data_ro = instret[63:32];

            CSR_SATP, CSR_MSTATUS, CSR_MNSTATUS, CSR_MEDELEG, CSR_MIDELEG,
            CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0: begin
                read_data_ro = '0;
            end

            default: begin
                // Performance windows are legal but read as zero
                read_known =
                    ((read_addr >= CSR_MPM_USER)
                     && (read_addr < CSR_MPM_USER + csr_addr_t'(MPM_WINDOW_SIZE)))
                    || ((read_addr >= CSR_MPM_USER_H)
                     && (read_addr < CSR_MPM_USER_H + csr_addr_t'(MPM_WINDOW_SIZE)));
            end
        endcase
    end

    assign read_addr_invalid = read_enable && !read_known;

endmodule

/* hdl/csr_pkg.sv */
/*
 * Shared widths, typedefs, identity constants and CSR addresses
 * for the core CSR data block
 */
package csr_pkg;

    // Datapath and machine sizes
    localparam int XLEN           = 32;
    localparam int NUM_WARPS      = 4;
    localparam int NUM_THREADS    = 4;
    localparam int NUM_FPU_BLOCKS = 2;
    localparam int NUM_CORES      = 8;
    localparam int NW_BITS        = $clog2(NUM_WARPS);

    // Floating-point control fields, mode sits above the flags
    localparam int FFLAGS_BITS = 5;
    localparam int FRM_BITS    = 3;
    localparam int FCSR_BITS   = FRM_BITS + FFLAGS_BITS;

    // Identity and configuration values
    localparam logic [XLEN-1:0] VENDOR_ID  = 32'h0000_0000;
    localparam logic [XLEN-1:0] ARCH_ID    = 32'h0000_0001;
    localparam logic [XLEN-1:0] IMPL_ID    = 32'h0000_0001;
    // RV32 with I, M and F extensions
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1120;
    localparam logic [XLEN-1:0] LMEM_BASE  = 32'hFFFF_0000;

    // Standard floating-point and machine CSRs
    localparam logic [11:0] CSR_FFLAGS    = 12'h001;
    localparam logic [11:0] CSR_FRM       = 12'h002;
    localparam logic [11:0] CSR_FCSR      = 12'h003;
    localparam logic [11:0] CSR_SATP      = 12'h180;
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MEDELEG   = 12'h302;
    localparam logic [11:0] CSR_MIDELEG   = 12'h303;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_PMPCFG0   = 12'h3A0;
    localparam logic [11:0] CSR_PMPADDR0  = 12'h3B0;
    localparam logic [11:0] CSR_MNSTATUS  = 12'h744;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;

    // Counters, low halves and high halves
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

    // User performance windows
    localparam logic [11:0] CSR_MPM_USER    = 12'hB03;
    localparam logic [11:0] CSR_MPM_USER_H  = 12'hB83;
    localparam int          MPM_WINDOW_SIZE = 32;

    // GPU specific block
    localparam logic [11:0] CSR_WARP_ID        = 12'hCC0;
    localparam logic [11:0] CSR_CORE_ID        = 12'hCC1;
    localparam logic [11:0] CSR_ACTIVE_THREADS = 12'hCC2;
    localparam logic [11:0] CSR_ACTIVE_WARPS   = 12'hCC3;
    localparam logic [11:0] CSR_NUM_THREADS    = 12'hCC4;
    localparam logic [11:0] CSR_NUM_WARPS      = 12'hCC5;
    localparam logic [11:0] CSR_NUM_CORES      = 12'hCC6;
    localparam logic [11:0] CSR_LOCAL_MEM_BASE = 12'hCC7;

    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [11:0]            csr_addr_t;
    typedef logic [NW_BITS-1:0]     wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [FFLAGS_BITS-1:0] fflags_t;
    typedef logic [FRM_BITS-1:0]    frm_t;
    typedef logic [FCSR_BITS-1:0]   fcsr_t;
    typedef logic [63:0]            ctr_t;

    // Which field of the control register a CSR write touches
    typedef enum logic [1:0] {
        NONE,
        FFLAGS,
        FRM,
        FCSR
    } fcsr_wr_e;

endpackage

/* hdl/fcsr_bank.sv */
/*
 * Per-warp floating-point control registers
 * FPU flag merging, CSR field writes and rounding-mode lookups
 */
`timescale 1ns/1ps

module fcsr_bank
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // CSR side write, already aligned to the register layout
    input  fcsr_wr_e  fcsr_wr_kind,
    input  wid_t      fcsr_wr_wid,
    input  fcsr_t     fcsr_wr_data,

    // CSR side read
    input  wid_t      read_wid,
    output fcsr_t     fcsr_rd_value,

    fpu_csr_if.bank   fpu [NUM_FPU_BLOCKS]
);

    fcsr_t [NUM_WARPS-1:0] fcsr_q;
    fcsr_t [NUM_WARPS-1:0] fcsr_d;

    // Flattened FPU update requests
    logic    [NUM_FPU_BLOCKS-1:0] upd_enable;
    wid_t    [NUM_FPU_BLOCKS-1:0] upd_wid;
    fflags_t [NUM_FPU_BLOCKS-1:0] upd_fflags;

    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_fpu_port
        assign upd_enable[i] = fpu[i].write_enable;
        assign upd_wid[i]    = fpu[i].write_wid;
        assign upd_fflags[i] = fpu[i].write_fflags;

        // Rounding mode straight from the registered state
        assign fpu[i].read_frm = fcsr_q[fpu[i].read_wid][FCSR_BITS-1:FFLAGS_BITS];
    end

    // Next state
    always_comb begin
        fcsr_d = fcsr_q;

        // Sticky flags, blocks hitting the same warp stack up
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            if (upd_enable[i]) begin
                fcsr_d[upd_wid[i]][FFLAGS_BITS-1:0] =
                    fcsr_d[upd_wid[i]][FFLAGS_BITS-1:0] | upd_fflags[i];
            end
        end

        // Software write overrides the merged field
        case (fcsr_wr_kind)
            FFLAGS: begin
                fcsr_d[fcsr_wr_wid][FFLAGS_BITS-1:0] = fcsr_wr_data[FFLAGS_BITS-1:0];
            end
            FRM: begin
                fcsr_d[fcsr_wr_wid][FCSR_BITS-1:FFLAGS_BITS] =
                    fcsr_wr_data[FCSR_BITS-1:FFLAGS_BITS];
            end
            FCSR: begin
                fcsr_d[fcsr_wr_wid] = fcsr_wr_data;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_q <= '0;
        end else begin
            fcsr_q <= fcsr_d;
        end
    end

    // Full value for the CSR read path
    assign fcsr_rd_value = fcsr_q[read_wid];

endmodule

/* hdl/fpu_csr_if.sv */
/*
 * Link between one FPU block and the control register bank
 */
`timescale 1ns/1ps

interface fpu_csr_if
    import csr_pkg::*;
();

    // Exception flag update from the FPU
    logic    write_enable;
    wid_t    write_wid;
    fflags_t write_fflags;

    // Rounding mode lookup
    wid_t    read_wid;
    frm_t    read_frm;

    modport fpu (
        output write_enable,
        output write_wid,
        output write_fflags,
        output read_wid,
        input  read_frm
    );

    modport bank (
        input  write_enable,
        input  write_wid,
        input  write_fflags,
        input  read_wid,
        output read_frm
    );

endinterface

/* list.f */
+incdir+include
hdl/csr_pkg.sv
hdl/fpu_csr_if.sv
hdl/fcsr_bank.sv
hdl/csr_machine_regs.sv
hdl/csr_data_unit.sv
sim/tb_csr_data_unit.sv

/* include/tb_csr_checks.svh */
/*
 * Checking helpers for the CSR data block testbench
 * Value checks, CSR read and write drivers, expected control fields
 */
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// Compare one value and report it in hex on a mismatch
task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    assert (actual === expected)
    else begin
        $display("ERR %s expected %h actual %h", name, expected, actual);
        error_count++;
    end
endtask

// One read cycle, sampled on the falling edge
task automatic read_check(input wid_t wid, input csr_addr_t addr,
                          input xlen_t exp_ro, input xlen_t exp_rw);
    @(posedge clk);
    read_enable <= 1'b1;
    read_wid    <= wid;
    read_addr   <= addr;
    @(negedge clk);
    check_value("read_data_ro", exp_ro, read_data_ro);
    check_value("read_data_rw", exp_rw, read_data_rw);
    check_value("read_addr_invalid", '0, xlen_t'(read_addr_invalid));
endtask

// CSR write held for a single edge
task automatic write_csr(input wid_t wid, input csr_addr_t addr, input xlen_t data,
                         input logic bad_addr);
    @(posedge clk);
    write_enable <= 1'b1;
    write_wid    <= wid;
    write_addr   <= addr;
    write_data   <= data;
    @(negedge clk);
    check_value("write_addr_invalid", xlen_t'(bad_addr), xlen_t'(write_addr_invalid));
    @(posedge clk);
    write_enable <= 1'b0;
endtask

// Flags sit in the low bits, rounding mode above them
function automatic fcsr_t set_flags(input fcsr_t old, input xlen_t data);
    return {old[FCSR_BITS-1:FFLAGS_BITS], data[FFLAGS_BITS-1:0]};
endfunction

function automatic fcsr_t set_mode(input fcsr_t old, input xlen_t data);
    return {data[FRM_BITS-1:0], old[FFLAGS_BITS-1:0]};
endfunction

// All three views of one warp's control register
task automatic check_fcsr(input wid_t wid);
    read_check(wid, CSR_FFLAGS, '0, xlen_t'(exp_fcsr[wid][FFLAGS_BITS-1:0]));
    read_check(wid, CSR_FRM, '0, xlen_t'(exp_fcsr[wid][FCSR_BITS-1:FFLAGS_BITS]));
    read_check(wid, CSR_FCSR, '0, xlen_t'(exp_fcsr[wid]));
endtask

task automatic finish_test(input string name);
    int new_errors;
    new_errors = error_count - mark_errors;
    if (new_errors == 0) begin
        tests_ok++;
        $display("%s: ok", name);
    end else begin
        tests_bad++;
        $display("%s: %0d errors", name, new_errors);
    end
    mark_errors = error_count;
endtask

`endif

/* sim/tb_csr_data_unit.sv */
/*
 * Testbench for the CSR data block
 * Clock, reset, directed and random stimulus, timeout and summary
 */
`timescale 1ns/1ps

module tb_csr_data_unit
    import csr_pkg::*;
();

    localparam int CORE_ID     = 5;
    localparam int CYCLE_LIMIT = 400;

    logic                         clk;
    logic                         reset;
    xlen_t                        startup_arg;
    ctr_t                         cycles;
    ctr_t                         instret;
    wmask_t                       active_warps;
    tmask_t  [NUM_WARPS-1:0]      thread_masks;
    logic                         read_enable;
    wid_t                         read_wid;
    csr_addr_t                    read_addr;
    logic                         write_enable;
    wid_t                         write_wid;
    csr_addr_t                    write_addr;
    xlen_t                        write_data;
    logic    [NUM_FPU_BLOCKS-1:0] fpu_flag_valid;
    wid_t    [NUM_FPU_BLOCKS-1:0] fpu_flag_wid;
    fflags_t [NUM_FPU_BLOCKS-1:0] fpu_flags;
    wid_t    [NUM_FPU_BLOCKS-1:0] fpu_frm_wid;
    xlen_t                        read_data_ro;
    xlen_t                        read_data_rw;
    logic                         read_addr_invalid;
    logic                         write_addr_invalid;
    frm_t    [NUM_FPU_BLOCKS-1:0] fpu_frm;

    integer seed        = 93;
    int     error_count = 0;
    int     mark_errors = 0;
    int     tests_ok    = 0;
    int     tests_bad   = 0;
    int     cycle_count = 0;
    xlen_t  scratch_value;
    xlen_t  rand_word;
    fcsr_t  exp_fcsr [NUM_WARPS] = '{default: '0};

    `include "tb_csr_checks.svh"

    csr_data_unit #(.CORE_ID(CORE_ID)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // A disabled read port never flags its address
    read_flag_gated: assert property (@(negedge clk) disable iff (reset)
        !read_enable |-> !read_addr_invalid)
        else begin
            $display("read_addr_invalid went high while read_enable was low");
            error_count++;
        end

    write_flag_gated: assert property (@(negedge clk) disable iff (reset)
        !write_enable |-> !write_addr_invalid)
        else begin
            $display("write_addr_invalid went high while write_enable was low");
            error_count++;
        end

    // Only one of the two read buses carries data
    read_split: assert property (@(negedge clk) disable iff (reset)
        (read_data_ro == '0) || (read_data_rw == '0))
        else begin
            $display("read_data_ro and read_data_rw were both nonzero");
            error_count++;
        end

    initial begin
        reset          = 1'b1;
        startup_arg    = $random(seed);
        cycles         = '0;
        instret        = '0;
        active_warps   = '0;
        thread_masks   = '0;
        read_enable    = 1'b0;
        read_wid       = '0;
        read_addr      = '0;
        write_enable   = 1'b0;
        write_wid      = '0;
        write_addr     = '0;
        write_data     = '0;
        fpu_flag_valid = '0;
        fpu_flag_wid   = '0;
        fpu_flags      = '0;
        fpu_frm_wid    = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int w = 0; w < NUM_WARPS; w++) begin
            check_fcsr(wid_t'(w));
        end
        read_check('0, CSR_MSCRATCH, '0, startup_arg);
        check_value("fpu_frm", '0, xlen_t'(fpu_frm));
        finish_test("reset_values");

        // Old value still visible during the write cycle
        scratch_value = $random(seed);
        @(posedge clk);
        write_enable <= 1'b1;
        write_addr   <= CSR_MSCRATCH;
        write_data   <= scratch_value;
        @(negedge clk);
        check_value("read_data_rw", startup_arg, read_data_rw);
        @(posedge clk);
        write_enable <= 1'b0;
        @(negedge clk);
        check_value("read_data_rw", scratch_value, read_data_rw);
        finish_test("scratch_register");

        rand_word = $random(seed);
        write_csr(2'd1, CSR_FRM, rand_word, 1'b0);
        exp_fcsr[1] = set_mode(exp_fcsr[1], rand_word);
        rand_word = $random(seed);
        write_csr(2'd2, CSR_FFLAGS, rand_word, 1'b0);
        exp_fcsr[2] = set_flags(exp_fcsr[2], rand_word);
        rand_word = $random(seed);
        write_csr(2'd3, CSR_FCSR, rand_word, 1'b0);
        exp_fcsr[3] = rand_word[FCSR_BITS-1:0];
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_fcsr(wid_t'(w));
        end
        @(posedge clk);
        fpu_frm_wid[0] <= 2'd1;
        fpu_frm_wid[1] <= 2'd3;
        @(negedge clk);
        check_value("fpu_frm[0]", xlen_t'(exp_fcsr[1][FCSR_BITS-1:FFLAGS_BITS]),
                    xlen_t'(fpu_frm[0]));
        check_value("fpu_frm[1]", xlen_t'(exp_fcsr[3][FCSR_BITS-1:FFLAGS_BITS]),
                    xlen_t'(fpu_frm[1]));
        finish_test("control_fields");

        // Old flags on warp 1 followed by both blocks at once
        @(posedge clk);
        fpu_flag_valid  <= 2'b01;
        fpu_flag_wid[0] <= 2'd1;
        fpu_flags[0]    <= 5'b01000;
        @(posedge clk);
        fpu_flag_valid  <= 2'b11;
        fpu_flag_wid[1] <= 2'd1;
        fpu_flags[0]    <= 5'b00011;
        fpu_flags[1]    <= 5'b10000;
        @(posedge clk);
        fpu_flag_valid  <= '0;
        exp_fcsr[1] |= fcsr_t'(5'b01000 | 5'b00011 | 5'b10000);
        check_fcsr(2'd1);

        // FFLAGS write on warp 1 wins while warp 0 still accumulates
        @(posedge clk);
        fpu_flag_valid  <= 2'b11;
        fpu_flag_wid[0] <= 2'd1;
        fpu_flags[0]    <= 5'b00100;
        fpu_flag_wid[1] <= 2'd0;
        fpu_flags[1]    <= 5'b00010;
        write_enable    <= 1'b1;
        write_wid       <= 2'd1;
        write_addr      <= CSR_FFLAGS;
        write_data      <= 32'h0000_0011;
        @(posedge clk);
        fpu_flag_valid  <= 2'b01;
        fpu_flag_wid[0] <= 2'd0;
        fpu_flags[0]    <= 5'b00001;
        write_wid       <= 2'd0;
        write_addr      <= CSR_FRM;
        write_data      <= 32'h0000_0006;
        exp_fcsr[1] = set_flags(exp_fcsr[1], 32'h0000_0011);
        exp_fcsr[0] |= fcsr_t'(5'b00010);
        // Mode write keeps the merged flags
        @(posedge clk);
        fpu_flag_valid  <= '0;
        write_enable    <= 1'b0;
        exp_fcsr[0] = set_mode(exp_fcsr[0] | fcsr_t'(5'b00001), 32'h0000_0006);
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_fcsr(wid_t'(w));
        end
        finish_test("flag_accumulation");

        rand_word = $random(seed);
        @(posedge clk);
        thread_masks <= rand_word[15:0];
        active_warps <= rand_word[19:16];
        cycles       <= {$random(seed), $random(seed)};
        instret      <= {$random(seed), $random(seed)};
        read_check(2'd2, CSR_WARP_ID, 32'd2, '0);
        read_check(2'd3, CSR_WARP_ID, 32'd3, '0);
        read_check('0, CSR_CORE_ID, xlen_t'(CORE_ID), '0);
        read_check(2'd3, CSR_ACTIVE_THREADS, xlen_t'(thread_masks[3]), '0);
        read_check(2'd1, CSR_ACTIVE_THREADS, xlen_t'(thread_masks[1]), '0);
        read_check('0, CSR_ACTIVE_WARPS, xlen_t'(active_warps), '0);
        read_check('0, CSR_NUM_THREADS, xlen_t'(NUM_THREADS), '0);
        read_check('0, CSR_NUM_WARPS, xlen_t'(NUM_WARPS), '0);
        read_check('0, CSR_NUM_CORES, xlen_t'(NUM_CORES), '0);
        read_check('0, CSR_MISA, MISA_VALUE, '0);
        read_check('0, CSR_MCYCLE, cycles[31:0], '0);
        read_check('0, CSR_MCYCLEH, cycles[63:32], '0);
        read_check('0, CSR_MINSTRET, instret[31:0], '0);
        read_check('0, CSR_MINSTRETH, instret[63:32], '0);
        read_check('0, CSR_MSTATUS, '0, '0);
        read_check('0, CSR_MTVEC, '0, '0);
        read_check('0, CSR_MEPC, '0, '0);
        finish_test("read_only_info");

        @(posedge clk);
        read_addr <= 12'h7C0;
        @(negedge clk);
        check_value("read_addr_invalid", 32'd1, xlen_t'(read_addr_invalid));
        @(posedge clk);
        read_enable <= 1'b0;
        @(negedge clk);
        check_value("read_addr_invalid", '0, xlen_t'(read_addr_invalid));
        read_check('0, CSR_MPM_USER + 12'd5, '0, '0);
        read_check('0, CSR_MPM_USER_H + 12'd31, '0, '0);
        write_csr(2'd1, 12'h7C0, $random(seed), 1'b1);
        write_csr(2'd2, CSR_MSTATUS, $random(seed), 1'b0);
        read_check('0, CSR_MSCRATCH, '0, scratch_value);
        read_check(2'd2, CSR_MSTATUS, '0, '0);
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_fcsr(wid_t'(w));
        end
        finish_test("address_checks");

        $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
